// File: filelist.f
verilog/ctrlPkg.sv
verilog/decodeIf.sv
verilog/instrFetchPort.sv
verilog/instrDecoder.sv
verilog/controlSequencer.sv
verilog/mipsControl.sv
verif/mipsControl_assertions.sv
verif/tbMipsControl.sv

// File: run.sh
#!/bin/sh
set -e
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tbMipsControl -f filelist.f
./obj_dir/VtbMipsControl > sim.log 2>&1
cat sim.log
if grep -q '\*\*\* FAILED \*\*\*' sim.log
then
    exit 1
fi
exit 0

// File: verif/tbMipsControl.sv
`timescale 1ns/1ns

module tbMipsControl import ctrlPkg::*;
();

    typedef struct packed {
        logic       fetchReq;
        logic       irWrite;
        logic       pcWrite;
        logic       pcWriteCond;
        logic [1:0] pcSrc;
        logic       memRead;
        logic       memWrite;
        logic [2:0] memRdWidth;
        logic [1:0] memWrWidth;
        logic       regWrite;
        logic [1:0] regDst;
        logic [1:0] memToReg;
        logic [1:0] aluSrcA;
        logic [1:0] aluSrcB;
        aluOpT      aluOp;
    } strobesT;

    logic        clk;
    logic        rst;
    logic        fetchReq;
    logic        fetchAck;
    logic [31:0] instr;
    logic        irWrite;
    logic        pcWrite;
    logic        pcWriteCond;
    logic [1:0]  pcSrc;
    logic        memRead;
    logic        memWrite;
    logic [2:0]  memRdWidth;
    logic [1:0]  memWrWidth;
    logic        regWrite;
    logic [1:0]  regDst;
    logic [1:0]  memToReg;
    logic [1:0]  aluSrcA;
    logic [1:0]  aluSrcB;
    aluOpT       aluOp;
    strobesT     actualVec;

    instrWord    instrQ [$];
    int          instrPerTest = 40;
    int          checks [6];
    int          errors [6];
    string       testNames [6] = '{"reset", "alu", "load store", "branch jump",
                                   "handshake", "illegal"};
    logic [5:0]  immOps [8] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
                                OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
    logic [5:0]  rFuncts [16] = '{F_SLL, F_SRL, F_SRA, F_SLLV, F_SRLV, F_SRAV, F_ADD, F_ADDU,
                                  F_SUB, F_SUBU, F_AND, F_OR, F_XOR, F_NOR, F_SLT, F_SLTU};
    logic [5:0]  memOps [8] = '{OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU, OP_SW, OP_SH, OP_SB};
    logic [5:0]  flowOps [6] = '{OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_J, OP_JAL};
    logic [5:0]  badOps [4] = '{6'h01, 6'h10, 6'h1c, 6'h3f};
    logic [5:0]  badFuncts [4] = '{6'h01, 6'h05, 6'h0c, 6'h3f};

    mipsControl u_mipsControl (.*);

    assign actualVec = {fetchReq, irWrite, pcWrite, pcWriteCond, pcSrc, memRead, memWrite,
                        memRdWidth, memWrWidth, regWrite, regDst, memToReg, aluSrcA, aluSrcB,
                        aluOp};

    always #10 clk = ~clk;

    function automatic instrClassT classOf(input instrWord w);
        case (w.iFields.op)
            OP_RTYPE:
            begin
                if (w.rFields.funct inside {F_JR, F_JALR})
                    return JUMP;
                if (w.rFields.funct inside {F_SLL, F_SRL, F_SRA, F_SLLV, F_SRLV, F_SRAV,
                                            F_ADD, F_ADDU, F_SUB, F_SUBU, F_AND, F_OR,
                                            F_XOR, F_NOR, F_SLT, F_SLTU})
                    return ALU_OP;
                return ILLEGAL;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
                return ALU_OP;
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: return LOAD;
            OP_SB, OP_SH, OP_SW:                 return STORE;
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ:    return BRANCH;
            OP_J, OP_JAL:                        return JUMP;
            default:                             return ILLEGAL;
        endcase
    endfunction

    function automatic aluOpT aluOpOf(input instrWord w);
        if (w.iFields.op == OP_RTYPE)
        begin
            case (w.rFields.funct)
                F_SUB, F_SUBU: return SUB;
                F_AND:         return AND;
                F_OR:          return OR;
                F_XOR:         return XOR;
                F_NOR:         return NOR;
                F_SLT:         return SLT;
                F_SLTU:        return SLTU;
                F_SLL, F_SLLV: return SLL;
                F_SRL, F_SRLV: return SRL;
                F_SRA, F_SRAV: return SRA;
                default:       return ADD;
            endcase
        end
        case (w.iFields.op)
            OP_SLTI:  return SLT;
            OP_SLTIU: return SLTU;
            OP_ANDI:  return ANDI;
            OP_ORI:   return ORI;
            OP_XORI:  return XORI;
            OP_LUI:   return LUI;
            OP_BEQ:   return SUB;
            OP_BNE:   return BNE;
            OP_BGTZ:  return BGTZ;
            OP_BLEZ:  return BLEZ;
            default:  return ADD;
        endcase
    endfunction

    // Cycles from DECODE to the next request
    function automatic int stepCount(input instrClassT cls);
        case (cls)
            ALU_OP, STORE: return 3;
            LOAD:          return 4;
            BRANCH, JUMP:  return 2;
            default:       return 1;
        endcase
    endfunction

    function automatic strobesT requestOnly();
        strobesT e;
        e = '0;
        e.fetchReq = 1'b1;
        return e;
    endfunction

    function automatic strobesT captureStrobes();
        strobesT e;
        e = requestOnly();
        e.irWrite = 1'b1;
        e.pcWrite = 1'b1;
        e.pcSrc = PC_INC;
        e.aluSrcA = SRCA_PC;
        e.aluSrcB = SRCB_FOUR;
        return e;
    endfunction

    // Step 0 is DECODE
    function automatic strobesT expectedStrobes(input instrWord w, input int s);
        strobesT    e;
        instrClassT cls;
        logic       isR;
        logic       link;
        cls = classOf(w);
        isR = (w.iFields.op == OP_RTYPE);
        link = isR ? (w.rFields.funct == F_JALR) : (w.iFields.op == OP_JAL);
        e = '0;
        if (s == 0)
        begin
            e.aluSrcA = SRCA_PC;
            e.aluSrcB = SRCB_IMMSHIFT;
        end
        else if (s == stepCount(cls))
            e = requestOnly();
        else
        begin
            case (cls)
                ALU_OP:
                begin
                    if (s == 1)
                    begin
                        e.aluSrcA = (isR && w.rFields.funct inside {F_SLL, F_SRL, F_SRA}) ?
                                    SRCA_SHAMT : SRCA_REG;
                        e.aluSrcB = isR ? SRCB_REG : SRCB_IMM;
                        e.aluOp = aluOpOf(w);
                    end
                    else
                    begin
                        e.regWrite = 1'b1;
                        e.memToReg = WB_ALU;
                        e.regDst = isR ? DST_RD : DST_RT;
                    end
                end
                LOAD, STORE:
                begin
                    if (s == 1)
                        e.aluSrcB = SRCB_IMM;         // Base register plus offset
                    else if (s == 3)
                    begin
                        e.regWrite = 1'b1;
                        e.regDst = DST_RT;
                        e.memToReg = WB_MEM;
                    end
                    else if (cls == LOAD)
                    begin
                        e.memRead = 1'b1;
                        case (w.iFields.op)
                            OP_LW:   e.memRdWidth = MR_W;
                            OP_LH:   e.memRdWidth = MR_H;
                            OP_LHU:  e.memRdWidth = MR_HU;
                            OP_LB:   e.memRdWidth = MR_B;
                            default: e.memRdWidth = MR_BU;
                        endcase
                    end
                    else
                    begin
                        e.memWrite = 1'b1;
                        case (w.iFields.op)
                            OP_SW:   e.memWrWidth = MW_W;
                            OP_SH:   e.memWrWidth = MW_H;
                            default: e.memWrWidth = MW_B;
                        endcase
                    end
                end
                BRANCH:
                begin
                    e.pcWriteCond = 1'b1;
                    e.pcSrc = PC_BRANCH;
                    e.aluOp = aluOpOf(w);
                end
                JUMP:
                begin
                    e.pcWrite = 1'b1;
                    e.pcSrc = isR ? PC_REG : PC_JUMP;
                    if (link)
                    begin
                        e.regWrite = 1'b1;
                        e.regDst = DST_RA;
                        e.memToReg = WB_LINK;
                    end
                end
                default:
                begin
                    e = '0;
                end
            endcase
        end
        return e;
    endfunction

    // Kind 0 ALU, 1 memory, 2 branch and jump, 3 mixed, 4 illegal
    function automatic instrWord randomInstr(input int kind);
        instrWord w;
        int       pick;
        w = $urandom;
        if (kind == 3)
            kind = ($urandom_range(0, 9) == 0) ? 4 : $urandom_range(0, 2);
        pick = $urandom_range(0, 23);
        case (kind)
            0:
            begin
                if (pick < 8)
                    w.iFields.op = immOps[pick];
                else
                begin
                    w.rFields.op = OP_RTYPE;
                    w.rFields.funct = rFuncts[pick - 8];
                end
            end
            1: w.iFields.op = memOps[pick % 8];
            2:
            begin
                if (pick < 18)
                    w.iFields.op = flowOps[pick % 6];
                else
                begin
                    w.rFields.op = OP_RTYPE;
                    w.rFields.funct = pick[0] ? F_JR : F_JALR;
                end
            end
            default:
            begin
                if (pick < 12)
                    w.iFields.op = badOps[pick % 4];
                else
                begin
                    w.rFields.op = OP_RTYPE;
                    w.rFields.funct = badFuncts[pick % 4];
                end
            end
        endcase
        return w;
    endfunction

    task automatic compareStrobes(input int t, input instrWord w, input string where,
                                  input strobesT expected);
        checks[t]++;
        if (actualVec !== expected)
        begin
            errors[t]++;
            $display("Error %s: instr %h at %s expected %h actual %h",
                     testNames[t], w, where, expected, actualVec);
        end
    endtask

    // One fetch through the last step, sampled at falling edges
    task automatic runInstr(input int t);
        instrWord w;
        int       pulses;
        int       s;
        w = '0;
        pulses = 0;
        @(negedge clk);
        while (!fetchAck)
        begin
            compareStrobes(t, w, "fetch wait", requestOnly());
            @(negedge clk);
        end
        w = instr;
        if (irWrite)
            pulses++;
        compareStrobes(t, w, "capture", captureStrobes());
        @(negedge clk);
        while (fetchAck)
        begin
            if (irWrite)
                pulses++;
            compareStrobes(t, w, "ack release", '0);
            @(negedge clk);
        end
        compareStrobes(t, w, "fetch done", '0);   // First cycle with ack low
        checks[t]++;
        if (pulses != 1)
        begin
            errors[t]++;
            $display("Error %s: instr %h irWrite pulses expected 1 actual %0d",
                     testNames[t], w, pulses);
        end
        for (s = 0; s <= stepCount(classOf(w)); s++)
        begin
            @(negedge clk);
            compareStrobes(t, w, $sformatf("step %0d", s), expectedStrobes(w, s));
        end
    endtask

    // Fetch source
    initial
    begin
        int delay;
        forever
        begin
            @(negedge clk);
            if (fetchReq && instrQ.size() > 0)
            begin
                delay = $urandom_range(0, 5);
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #2;
                instr = instrQ.pop_front();
                fetchAck = 1'b1;
                do
                begin
                    @(negedge clk);
                end
                while (fetchReq);
                delay = $urandom_range(0, 3);
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #2;
                fetchAck = 1'b0;
            end
        end
    end

    initial
    begin
        #((5 * instrPerTest * 20 + 100) * 20);
        $display("Timeout: the tests did not complete in the expected time");
        $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        int i;
        int k;
        int totalChecks;
        int totalErrors;
        clk = 1'b0;
        rst = 1'b1;
        fetchAck = 1'b0;
        instr = '0;
        void'($urandom(58));
        for (k = 0; k < 5; k++)
        begin
            for (i = 0; i < instrPerTest; i++)
                instrQ.push_back(randomInstr(k));
        end
        @(posedge clk);
        @(negedge clk);
        compareStrobes(0, '0, "reset", '0);
        @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        compareStrobes(0, '0, "reset release", '0);
        @(negedge clk);
        compareStrobes(0, '0, "first fetch", requestOnly());
        $display("Test 1 %s: %0d checks, %0d errors", testNames[0], checks[0], errors[0]);
        for (k = 1; k < 6; k++)
        begin
            for (i = 0; i < instrPerTest; i++)
                runInstr(k);
            $display("Test %0d %s: %0d checks, %0d errors", k + 1, testNames[k],
                     checks[k], errors[k]);
        end
        totalChecks = 0;
        totalErrors = 0;
        for (k = 0; k < 6; k++)
        begin
            totalChecks += checks[k];
            totalErrors += errors[k];
        end
        $display("Total: %0d checks, %0d errors", totalChecks, totalErrors);
        if (totalErrors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: verif/mipsControl_assertions.sv
`timescale 1ns/1ns

module mipsControl_assertions
(
    input logic clk,
    input logic rst,
    input logic fetchReq,
    input logic fetchAck,
    input logic irWrite,
    input logic memRead,
    input logic memWrite
);

    // Request stays up until the source answers
    reqHeld: assert property (@(posedge clk) disable iff (rst)
                              fetchReq && !fetchAck |=> fetchReq)
        else $error("fetchReq dropped before fetchAck was seen");

    memExclusive: assert property (@(posedge clk) disable iff (rst) !(memRead && memWrite))
        else $error("memRead and memWrite high in the same cycle");

    irWriteOnce: assert property (@(posedge clk) disable iff (rst) irWrite |=> !irWrite)
        else $error("irWrite held longer than one cycle");

endmodule

bind mipsControl mipsControl_assertions u_assertions (
    .clk      (clk),
    .rst      (rst),
    .fetchReq (fetchReq),
    .fetchAck (fetchAck),
    .irWrite  (irWrite),
    .memRead  (memRead),
    .memWrite (memWrite)
);

// File: verilog/mipsControl.sv
`timescale 1ns/1ns

module mipsControl import ctrlPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    output logic        fetchReq,
    input  logic        fetchAck,
    input  logic [31:0] instr,
    output logic        irWrite,
    output logic        pcWrite,
    output logic        pcWriteCond,
    output logic [1:0]  pcSrc,
    output logic        memRead,
    output logic        memWrite,
    output logic [2:0]  memRdWidth,
    output logic [1:0]  memWrWidth,
    output logic        regWrite,
    output logic [1:0]  regDst,
    output logic [1:0]  memToReg,
    output logic [1:0]  aluSrcA,
    output logic [1:0]  aluSrcB,
    output aluOpT       aluOp
);

    instrWord ir;
    logic     fetchStart;
    logic     fetchDone;

    decodeIf decBus ();

    instrFetchPort u_fetchPort (
        .clk        (clk),
        .rst        (rst),
        .fetchStart (fetchStart),
        .fetchAck   (fetchAck),
        .instr      (instr),
        .fetchReq   (fetchReq),
        .irWrite    (irWrite),
        .fetchDone  (fetchDone),
        .ir         (ir)
    );

    instrDecoder u_decoder (
        .ir  (ir),
        .dec (decBus)
    );

    controlSequencer u_sequencer (
        .clk         (clk),
        .rst         (rst),
        .dec         (decBus),
        .fetchDone   (fetchDone),
        .irWrite     (irWrite),
        .fetchStart  (fetchStart),
        .pcWrite     (pcWrite),
        .pcWriteCond (pcWriteCond),
        .pcSrc       (pcSrc),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .memRdWidth  (memRdWidth),
        .memWrWidth  (memWrWidth),
        .regWrite    (regWrite),
        .regDst      (regDst),
        .memToReg    (memToReg),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .aluOp       (aluOp)
    );

endmodule

// File: verilog/controlSequencer.sv
`timescale 1ns/1ns

module controlSequencer import ctrlPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    decodeIf.sink      dec,
    input  logic       fetchDone,
    input  logic       irWrite,
    output logic       fetchStart,
    output logic       pcWrite,
    output logic       pcWriteCond,
    output logic [1:0] pcSrc,
    output logic       memRead,
    output logic       memWrite,
    output logic [2:0] memRdWidth,
    output logic [1:0] memWrWidth,
    output logic       regWrite,
    output logic [1:0] regDst,
    output logic [1:0] memToReg,
    output logic [1:0] aluSrcA,
    output logic [1:0] aluSrcB,
    output aluOpT      aluOp
);

    seqStateT state;
    seqStateT nextState;

    assign fetchStart = (state == FETCH);

    always_comb
    begin
        case (state)
            FETCH: nextState = fetchDone ? DECODE : FETCH;
            DECODE:
            begin
                case (dec.instrClass)
                    ALU_OP:      nextState = EXEC;
                    LOAD, STORE: nextState = MEM_ADDR;
                    BRANCH:      nextState = BRANCH_DONE;
                    JUMP:        nextState = JUMP_DONE;
                    default:     nextState = FETCH;   // Unknown opcode or funct
                endcase
            end
            EXEC:     nextState = ALU_WB;
            MEM_ADDR: nextState = (dec.instrClass == LOAD) ? MEM_LOAD : MEM_STORE;
            MEM_LOAD: nextState = LOAD_WB;
            default:  nextState = FETCH;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= FETCH;
        end
        else
        begin
            state <= nextState;
        end
    end

    always_comb
    begin
        pcWrite     = 1'b0;
        pcWriteCond = 1'b0;
        pcSrc       = 2'b00;
        memRead     = 1'b0;
        memWrite    = 1'b0;
        memRdWidth  = 3'd0;
        memWrWidth  = 2'd0;
        regWrite    = 1'b0;
        regDst      = 2'b00;
        memToReg    = 2'b00;
        aluSrcA     = 2'b00;
        aluSrcB     = 2'b00;
        aluOp       = ADD;
        case (state)
            FETCH:
            begin
                pcWrite = irWrite;                    // PC + 4 on capture
                pcSrc   = PC_INC;
                aluSrcA = irWrite ? SRCA_PC : 2'b00;
                aluSrcB = irWrite ? SRCB_FOUR : 2'b00;
            end
            DECODE:
            begin
                aluSrcA = SRCA_PC;                    // Branch target precompute
                aluSrcB = SRCB_IMMSHIFT;
            end
            EXEC:
            begin
                aluSrcA = dec.aluSrcA;
                aluSrcB = dec.aluSrcB;
                aluOp   = dec.aluOp;
            end
            ALU_WB:
            begin
                regWrite = 1'b1;
                regDst   = dec.regDst;
                memToReg = WB_ALU;
            end
            MEM_ADDR:
            begin
                aluSrcA = SRCA_REG;
                aluSrcB = SRCB_IMM;
            end
            MEM_LOAD:
            begin
                memRead    = 1'b1;
                memRdWidth = dec.memRdWidth;
            end
            LOAD_WB:
            begin
                regWrite = 1'b1;
                regDst   = DST_RT;
                memToReg = WB_MEM;
            end
            MEM_STORE:
            begin
                memWrite   = 1'b1;
                memWrWidth = dec.memWrWidth;
            end
            BRANCH_DONE:
            begin
                pcWriteCond = 1'b1;
                pcSrc       = PC_BRANCH;
                aluSrcA     = SRCA_REG;
                aluSrcB     = SRCB_REG;               // Compare-to-zero ops ignore B
                aluOp       = dec.aluOp;
            end
            JUMP_DONE:
            begin
                pcWrite  = 1'b1;
                pcSrc    = dec.pcJumpSrc;
                regWrite = dec.linkWrite;
                regDst   = dec.linkWrite ? DST_RA : 2'b00;
                memToReg = dec.linkWrite ? WB_LINK : 2'b00;
            end
            default:
            begin
                pcWrite = 1'b0;
            end
        endcase
    end

endmodule

// File: verilog/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder import ctrlPkg::*;
(
    input  instrWord ir,
    decodeIf.source  dec
);

    always_comb
    begin
        dec.instrClass = ILLEGAL;
        dec.aluOp      = ADD;
        dec.aluSrcA    = SRCA_REG;
        dec.aluSrcB    = SRCB_REG;
        dec.regDst     = DST_RT;
        dec.linkWrite  = 1'b0;
        dec.pcJumpSrc  = PC_JUMP;
        dec.memRdWidth = 3'd0;
        dec.memWrWidth = 2'd0;
        case (ir.iFields.op)
            OP_RTYPE:
            begin
                dec.instrClass = ALU_OP;
                dec.regDst     = DST_RD;
                case (ir.rFields.funct)
                    F_ADD, F_ADDU: dec.aluOp = ADD;
                    F_SUB, F_SUBU: dec.aluOp = SUB;
                    F_AND:         dec.aluOp = AND;
                    F_OR:          dec.aluOp = OR;
                    F_XOR:         dec.aluOp = XOR;
                    F_NOR:         dec.aluOp = NOR;
                    F_SLT:         dec.aluOp = SLT;
                    F_SLTU:        dec.aluOp = SLTU;
                    F_SLLV:        dec.aluOp = SLL;
                    F_SRLV:        dec.aluOp = SRL;
                    F_SRAV:        dec.aluOp = SRA;
                    F_SLL, F_SRL, F_SRA:
                    begin
                        dec.aluSrcA = SRCA_SHAMT;     // Shift amount from the shamt field
                        dec.aluOp   = (ir.rFields.funct == F_SLL) ? SLL :
                                      (ir.rFields.funct == F_SRL) ? SRL : SRA;
                    end
                    F_JR, F_JALR:
                    begin
                        dec.instrClass = JUMP;
                        dec.pcJumpSrc  = PC_REG;
                        dec.linkWrite  = (ir.rFields.funct == F_JALR);
                    end
                    default: dec.instrClass = ILLEGAL;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
            begin
                dec.instrClass = ALU_OP;
                dec.aluSrcB    = SRCB_IMM;
                case (ir.iFields.op)
                    OP_SLTI:  dec.aluOp = SLT;
                    OP_SLTIU: dec.aluOp = SLTU;
                    OP_ANDI:  dec.aluOp = ANDI;
                    OP_ORI:   dec.aluOp = ORI;
                    OP_XORI:  dec.aluOp = XORI;
                    OP_LUI:   dec.aluOp = LUI;
                    default:  dec.aluOp = ADD;        // addi, addiu
                endcase
            end
            OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU:
            begin
                dec.instrClass = LOAD;
                case (ir.iFields.op)
                    OP_LW:   dec.memRdWidth = MR_W;
                    OP_LH:   dec.memRdWidth = MR_H;
                    OP_LHU:  dec.memRdWidth = MR_HU;
                    OP_LB:   dec.memRdWidth = MR_B;
                    default: dec.memRdWidth = MR_BU;
                endcase
            end
            OP_SW, OP_SH, OP_SB:
            begin
                dec.instrClass = STORE;
                dec.memWrWidth = (ir.iFields.op == OP_SW) ? MW_W :
                                 (ir.iFields.op == OP_SH) ? MW_H : MW_B;
            end
            OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ:
            begin
                dec.instrClass = BRANCH;
                case (ir.iFields.op)
                    OP_BEQ:  dec.aluOp = SUB;         // Taken on zero result
                    OP_BNE:  dec.aluOp = BNE;
                    OP_BGTZ: dec.aluOp = BGTZ;
                    default: dec.aluOp = BLEZ;
                endcase
            end
            OP_J, OP_JAL:
            begin
                dec.instrClass = JUMP;
                dec.linkWrite  = (ir.iFields.op == OP_JAL);
            end
            default: dec.instrClass = ILLEGAL;
        endcase
    end

endmodule

// File: verilog/instrFetchPort.sv
`timescale 1ns/1ns

module instrFetchPort import ctrlPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     fetchStart,
    input  logic     fetchAck,
    input  instrWord instr,
    output logic     fetchReq,
    output logic     irWrite,
    output logic     fetchDone,
    output instrWord ir
);

    logic [1:0] phase;

    // Request goes up as soon as the sequencer enters FETCH
    assign fetchReq  = (phase == FP_REQ) || ((phase == FP_IDLE) && fetchStart);
    assign irWrite   = fetchReq && fetchAck;
    assign fetchDone = (phase == FP_RELEASE) && !fetchAck;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            phase <= FP_HOLD;                         // Keeps fetchReq low through reset
        end
        else
        begin
            case (phase)
                FP_HOLD:    phase <= FP_IDLE;
                FP_RELEASE: phase <= fetchAck ? FP_RELEASE : FP_IDLE;
                default:    phase <= irWrite ? FP_RELEASE : (fetchReq ? FP_REQ : FP_IDLE);
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (irWrite)
        begin
            ir <= instr;
        end
    end

endmodule

// File: verilog/decodeIf.sv
`timescale 1ns/1ns

interface decodeIf import ctrlPkg::*; ();

    instrClassT instrClass;
    aluOpT      aluOp;
    logic [1:0] aluSrcA;
    logic [1:0] aluSrcB;
    logic [1:0] regDst;                               // ALU result destination
    logic       linkWrite;                            // jal, jalr
    logic [1:0] pcJumpSrc;
    logic [2:0] memRdWidth;
    logic [1:0] memWrWidth;

    modport source (output instrClass, aluOp, aluSrcA, aluSrcB, regDst, linkWrite,
                    pcJumpSrc, memRdWidth, memWrWidth);
    modport sink (input instrClass, aluOp, aluSrcA, aluSrcB, regDst, linkWrite,
                  pcJumpSrc, memRdWidth, memWrWidth);

endinterface

// File: verilog/ctrlPkg.sv
package ctrlPkg;

    // Primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_BLEZ  = 6'h06;
    localparam logic [5:0] OP_BGTZ  = 6'h07;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_SLTIU = 6'h0b;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LB    = 6'h20;
    localparam logic [5:0] OP_LH    = 6'h21;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_LBU   = 6'h24;
    localparam logic [5:0] OP_LHU   = 6'h25;
    localparam logic [5:0] OP_SB    = 6'h28;
    localparam logic [5:0] OP_SH    = 6'h29;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type funct field
    localparam logic [5:0] F_SLL  = 6'h00;
    localparam logic [5:0] F_SRL  = 6'h02;
    localparam logic [5:0] F_SRA  = 6'h03;
    localparam logic [5:0] F_SLLV = 6'h04;
    localparam logic [5:0] F_SRLV = 6'h06;
    localparam logic [5:0] F_SRAV = 6'h07;
    localparam logic [5:0] F_JR   = 6'h08;
    localparam logic [5:0] F_JALR = 6'h09;
    localparam logic [5:0] F_ADD  = 6'h20;
    localparam logic [5:0] F_ADDU = 6'h21;
    localparam logic [5:0] F_SUB  = 6'h22;
    localparam logic [5:0] F_SUBU = 6'h23;
    localparam logic [5:0] F_AND  = 6'h24;
    localparam logic [5:0] F_OR   = 6'h25;
    localparam logic [5:0] F_XOR  = 6'h26;
    localparam logic [5:0] F_NOR  = 6'h27;
    localparam logic [5:0] F_SLT  = 6'h2a;
    localparam logic [5:0] F_SLTU = 6'h2b;

    typedef enum logic [4:0] {
        ADD, SUB, AND, OR, XOR, NOR, SLL, SRL, SRA,
        SLT, SLTU, LUI, BNE, BGTZ, BLEZ,
        ANDI, ORI, XORI                               // Zero-extended logic ops
    } aluOpT;

    localparam logic [1:0] SRCA_REG      = 2'd0;
    localparam logic [1:0] SRCA_PC       = 2'd1;
    localparam logic [1:0] SRCA_SHAMT    = 2'd2;
    localparam logic [1:0] SRCB_REG      = 2'd0;
    localparam logic [1:0] SRCB_FOUR     = 2'd1;
    localparam logic [1:0] SRCB_IMM      = 2'd2;  // Sign-extended
    localparam logic [1:0] SRCB_IMMSHIFT = 2'd3;  // Sign-extended, shifted by 2
    localparam logic [1:0] DST_RT        = 2'd0;
    localparam logic [1:0] DST_RD        = 2'd1;
    localparam logic [1:0] DST_RA        = 2'd2;  // Register 31
    localparam logic [1:0] WB_MEM        = 2'd0;
    localparam logic [1:0] WB_ALU        = 2'd1;
    localparam logic [1:0] WB_LINK       = 2'd2;  // PC + 4
    localparam logic [1:0] PC_INC        = 2'd0;
    localparam logic [1:0] PC_BRANCH     = 2'd1;
    localparam logic [1:0] PC_JUMP       = 2'd2;
    localparam logic [1:0] PC_REG        = 2'd3;

    // Memory access widths, zero means no access
    localparam logic [2:0] MR_W  = 3'd1;
    localparam logic [2:0] MR_H  = 3'd2;
    localparam logic [2:0] MR_HU = 3'd3;
    localparam logic [2:0] MR_B  = 3'd4;
    localparam logic [2:0] MR_BU = 3'd5;
    localparam logic [1:0] MW_W  = 2'd1;
    localparam logic [1:0] MW_H  = 2'd2;
    localparam logic [1:0] MW_B  = 2'd3;

    // Fetch port phases
    localparam logic [1:0] FP_HOLD    = 2'd0;
    localparam logic [1:0] FP_IDLE    = 2'd1;
    localparam logic [1:0] FP_REQ     = 2'd2;
    localparam logic [1:0] FP_RELEASE = 2'd3;

    typedef enum logic [2:0] {ALU_OP, LOAD, STORE, BRANCH, JUMP, ILLEGAL} instrClassT;

    typedef enum logic [3:0] {
        FETCH, DECODE, EXEC, ALU_WB, MEM_ADDR, MEM_LOAD,
        LOAD_WB, MEM_STORE, BRANCH_DONE, JUMP_DONE
    } seqStateT;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFieldsT;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;                             // Also low half of the jump target
    } iFieldsT;

    typedef union packed {
        rFieldsT rFields;
        iFieldsT iFields;
    } instrWord;

endpackage
